// File: include/laser_game_cfg.svh
`ifndef LASER_GAME_CFG_SVH
`define LASER_GAME_CFG_SVH

// Reduced horizontal scan in pixel clocks
`define LG_H_ACTIVE      32
`define LG_H_TOTAL       40
`define LG_HS_START      34
`define LG_HS_END        37

// Reduced vertical scan in lines
`define LG_V_ACTIVE      24
`define LG_V_TOTAL       28
`define LG_VS_START      25
`define LG_VS_END        26

`define LG_COORD_W       6

// Laser geometry and pacing
`define LG_LASER_TOP     4
`define LG_LASER_BOTTOM  19
`define LG_LASER_X0      8
`define LG_LASER_X1      16
`define LG_LASER_X2      24
`define LG_LASER_GROW    3
`define LG_GROW_TICKS    150
`define LG_HOLD_TICKS    600

// Player bar
`define LG_PLAYER_TOP    16
`define LG_PLAYER_BOTTOM 21
`define LG_PLAYER_W      4

`define LG_BG_RGB        12'h124
`define LG_LASER_RGB     12'hfff
`define LG_PLAYER_RGB    12'h0f0

`endif

// File: src/laser_game_pkg.sv
`include "laser_game_cfg.svh"

package laser_game_pkg;

  ////////////////////////////////////////////////////////////
  // Scan position with its syncs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`LG_COORD_W-1:0] hcount;
    logic [`LG_COORD_W-1:0] vcount;
    logic                   hsync;
    logic                   vsync;
    logic                   blank;
  } scan_t;

  // One pixel between processing stages
  typedef struct packed {
    scan_t       scan;
    logic [11:0] rgb;
    logic        laser;
  } pixel_t;

  typedef enum logic [1:0] {
    LASER_IDLE   = 2'd0,
    LASER_LEFT   = 2'd1,
    LASER_MIDDLE = 2'd2,
    LASER_RIGHT  = 2'd3
  } laser_state_t;

  // Syncs inactive and pixel blanked
  localparam scan_t SCAN_RESET = '{
    hcount: '0,
    vcount: '0,
    hsync:  1'b1,
    vsync:  1'b1,
    blank:  1'b1
  };

  localparam pixel_t PIXEL_RESET = '{scan: SCAN_RESET, rgb: 12'h000, laser: 1'b0};

endpackage

// File: src/vga_timing.sv
`timescale 1ns/1ns
`include "laser_game_cfg.svh"

module vga_timing (
  input  logic                  pclk,
  input  logic                  rst,
  output laser_game_pkg::scan_t scan
);

  localparam int W = `LG_COORD_W;

  localparam logic [W-1:0] H_LAST   = W'(`LG_H_TOTAL - 1);
  localparam logic [W-1:0] V_LAST   = W'(`LG_V_TOTAL - 1);
  localparam logic [W-1:0] H_ACTIVE = W'(`LG_H_ACTIVE);
  localparam logic [W-1:0] V_ACTIVE = W'(`LG_V_ACTIVE);
  localparam logic [W-1:0] HS_START = W'(`LG_HS_START);
  localparam logic [W-1:0] HS_END   = W'(`LG_HS_END);
  localparam logic [W-1:0] VS_START = W'(`LG_VS_START);
  localparam logic [W-1:0] VS_END   = W'(`LG_VS_END);

  logic [W-1:0] hcnt;
  logic [W-1:0] vcnt;
  logic         line_end;

  laser_game_pkg::scan_t scan_nxt;

  assign line_end = (hcnt == H_LAST);

  ////////////////////////////////////////////////////////////
  // Scan counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (line_end) begin
      hcnt <= '0;
      if (vcnt == V_LAST) begin
        vcnt <= '0;
      end else begin
        vcnt <= vcnt + 1'b1;
      end
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // Syncs are active low
  always_comb begin
    scan_nxt.hcount = hcnt;
    scan_nxt.vcount = vcnt;
    scan_nxt.hsync  = !((hcnt >= HS_START) && (hcnt < HS_END));
    scan_nxt.vsync  = !((vcnt >= VS_START) && (vcnt < VS_END));
    scan_nxt.blank  = (hcnt >= H_ACTIVE) || (vcnt >= V_ACTIVE);
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      scan <= laser_game_pkg::SCAN_RESET;
    end else begin
      scan <= scan_nxt;
    end
  end

endmodule

// File: src/laser_obstacle.sv
`timescale 1ns/1ns
`include "laser_game_cfg.svh"

module laser_obstacle (
  input  logic                   pclk,
  input  logic                   rst,
  input  logic                   game_on,
  input  logic                   menu_on,
  input  laser_game_pkg::scan_t  scan,
  output laser_game_pkg::pixel_t pix
);

  localparam int W      = `LG_COORD_W;
  localparam int TICK_W = $clog2(`LG_HOLD_TICKS);
  localparam int STEP_W = $clog2(`LG_LASER_GROW + 1);

  localparam logic [W-1:0]      X0         = W'(`LG_LASER_X0);
  localparam logic [W-1:0]      X1         = W'(`LG_LASER_X1);
  localparam logic [W-1:0]      X2         = W'(`LG_LASER_X2);
  localparam logic [W-1:0]      LASER_TOP  = W'(`LG_LASER_TOP);
  localparam logic [W-1:0]      LASER_BOT  = W'(`LG_LASER_BOTTOM);
  localparam logic [TICK_W-1:0] GROW_LAST  = TICK_W'(`LG_GROW_TICKS - 1);
  localparam logic [TICK_W-1:0] HOLD_LAST  = TICK_W'(`LG_HOLD_TICKS - 1);
  localparam logic [STEP_W-1:0] GROW_STEPS = STEP_W'(`LG_LASER_GROW);

  laser_game_pkg::laser_state_t state, state_nxt;

  logic [W-1:0]      left, left_nxt;
  logic [W-1:0]      right, right_nxt;
  logic [TICK_W-1:0] tick, tick_nxt;
  logic [STEP_W-1:0] steps, steps_nxt;
  logic              on_beam;

  laser_game_pkg::pixel_t pix_nxt;

  ////////////////////////////////////////////////////////////
  // Beam state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      state <= laser_game_pkg::LASER_IDLE;
      left  <= '0;
      right <= '0;
      tick  <= '0;
      steps <= '0;
    end else begin
      state <= state_nxt;
      left  <= left_nxt;
      right <= right_nxt;
      tick  <= tick_nxt;
      steps <= steps_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    left_nxt  = left;
    right_nxt = right;
    tick_nxt  = tick;
    steps_nxt = steps;
    case (state)
      laser_game_pkg::LASER_IDLE: begin
        if (game_on && !menu_on) begin
          state_nxt = laser_game_pkg::LASER_LEFT;
          left_nxt  = X0;
          right_nxt = X0 + 1'b1;
          tick_nxt  = '0;
          steps_nxt = '0;
        end
      end
      default: begin
        if (menu_on || !game_on) begin
          state_nxt = laser_game_pkg::LASER_IDLE;
        end else if (steps != GROW_STEPS) begin
          // Widening phase
          if (tick == GROW_LAST) begin
            left_nxt  = left - 1'b1;
            right_nxt = right + 1'b1;
            steps_nxt = steps + 1'b1;
            tick_nxt  = '0;
          end else begin
            tick_nxt = tick + 1'b1;
          end
        end else if (tick == HOLD_LAST) begin
          // Hold over, hand over to the next beam
          tick_nxt  = '0;
          steps_nxt = '0;
          case (state)
            laser_game_pkg::LASER_LEFT: begin
              state_nxt = laser_game_pkg::LASER_MIDDLE;
              left_nxt  = X1;
              right_nxt = X1 + 1'b1;
            end
            laser_game_pkg::LASER_MIDDLE: begin
              state_nxt = laser_game_pkg::LASER_RIGHT;
              left_nxt  = X2;
              right_nxt = X2 + 1'b1;
            end
            default: begin
              state_nxt = laser_game_pkg::LASER_IDLE;
            end
          endcase
        end else begin
          tick_nxt = tick + 1'b1;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Beam painting
  ////////////////////////////////////////////////////////////

  assign on_beam = (state != laser_game_pkg::LASER_IDLE) &&
                   (scan.hcount >= left) && (scan.hcount <= right) &&
                   (scan.vcount >= LASER_TOP) && (scan.vcount <= LASER_BOT);

  always_comb begin
    pix_nxt.scan  = scan;
    pix_nxt.rgb   = on_beam ? `LG_LASER_RGB : `LG_BG_RGB;
    pix_nxt.laser = on_beam;
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      pix <= laser_game_pkg::PIXEL_RESET;
    end else begin
      pix <= pix_nxt;
    end
  end

endmodule

// File: src/player_collision.sv
`timescale 1ns/1ns
`include "laser_game_cfg.svh"

module player_collision (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic                    game_on,
  input  logic [`LG_COORD_W-1:0]  player_x,
  input  laser_game_pkg::pixel_t  pix_in,
  output laser_game_pkg::pixel_t  pix_out,
  output logic                    hit
);

  localparam int W = `LG_COORD_W;

  localparam logic [W-1:0] PLAYER_TOP = W'(`LG_PLAYER_TOP);
  localparam logic [W-1:0] PLAYER_BOT = W'(`LG_PLAYER_BOTTOM);
  localparam logic [W:0]   SPAN       = (W+1)'(`LG_PLAYER_W - 1);

  logic [W-1:0] player_col;
  logic [W:0]   col_end;
  logic         frame_start;
  logic         in_rows;
  logic         in_cols;
  logic         on_player;

  laser_game_pkg::pixel_t pix_nxt;

  assign frame_start = (pix_in.scan.hcount == '0) && (pix_in.scan.vcount == '0);

  // Column holds for the whole frame
  always_ff @(posedge pclk) begin
    if (frame_start) begin
      player_col <= player_x;
    end
  end

  // One extra bit so the right edge cannot wrap
  assign col_end = {1'b0, player_col} + SPAN;

  assign in_rows   = (pix_in.scan.vcount >= PLAYER_TOP) && (pix_in.scan.vcount <= PLAYER_BOT);
  assign in_cols   = (pix_in.scan.hcount >= player_col) &&
                     ({1'b0, pix_in.scan.hcount} <= col_end);
  assign on_player = game_on && in_rows && in_cols;

  // Laser stays on top of the bar
  always_comb begin
    pix_nxt = pix_in;
    if (on_player && !pix_in.laser) begin
      pix_nxt.rgb = `LG_PLAYER_RGB;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      pix_out <= laser_game_pkg::PIXEL_RESET;
      hit     <= 1'b0;
    end else begin
      pix_out <= pix_nxt;
      hit     <= on_player && pix_in.laser;
    end
  end

endmodule

// File: src/vga_out.sv
`timescale 1ns/1ns

module vga_out (
  input  logic                   pclk,
  input  logic                   rst,
  input  laser_game_pkg::pixel_t pix,
  input  logic                   hit_in,
  output logic                   hsync,
  output logic                   vsync,
  output logic [11:0]            rgb,
  output logic                   hit_out
);

  logic visible;

  assign visible = !pix.scan.blank;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      rgb     <= 12'h000;
      hit_out <= 1'b0;
    end else begin
      hsync <= pix.scan.hsync;
      vsync <= pix.scan.vsync;
      // Nothing but black outside the active area
      if (visible) begin
        rgb     <= pix.rgb;
        hit_out <= hit_in;
      end else begin
        rgb     <= 12'h000;
        hit_out <= 1'b0;
      end
    end
  end

endmodule

// File: src/laser_game_top.sv
`timescale 1ns/1ns
`include "laser_game_cfg.svh"

module laser_game_top (
  input  logic                   pclk,
  input  logic                   rst,
  input  logic                   game_on,
  input  logic                   menu_on,
  input  logic [`LG_COORD_W-1:0] player_x,
  output logic                   hsync,
  output logic                   vsync,
  output logic [11:0]            rgb,
  output logic                   hit
);

  laser_game_pkg::scan_t  scan;
  laser_game_pkg::pixel_t laser_pix;
  laser_game_pkg::pixel_t player_pix;
  logic                   player_hit;

  // Input side
  vga_timing u_vga_timing (
    .pclk (pclk),
    .rst  (rst),
    .scan (scan)
  );

  ////////////////////////////////////////////////////////////
  // Processing
  ////////////////////////////////////////////////////////////

  laser_obstacle u_laser_obstacle (
    .pclk    (pclk),
    .rst     (rst),
    .game_on (game_on),
    .menu_on (menu_on),
    .scan    (scan),
    .pix     (laser_pix)
  );

  player_collision u_player_collision (
    .pclk     (pclk),
    .rst      (rst),
    .game_on  (game_on),
    .player_x (player_x),
    .pix_in   (laser_pix),
    .pix_out  (player_pix),
    .hit      (player_hit)
  );

  // Output side
  vga_out u_vga_out (
    .pclk    (pclk),
    .rst     (rst),
    .pix     (player_pix),
    .hit_in  (player_hit),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb),
    .hit_out (hit)
  );

endmodule

// File: tests/laser_game_checker.sv
`timescale 1ns/1ns
`include "laser_game_cfg.svh"

module laser_game_checker (
  input  logic                   pclk,
  input  logic                   rst,
  input  logic                   game_on,
  input  logic                   menu_on,
  input  logic [`LG_COORD_W-1:0] player_x,
  input  logic                   hsync,
  input  logic                   vsync,
  input  logic [11:0]            rgb,
  input  logic                   hit,
  output int                     error_count,
  output int                     check_count,
  output int                     hit_count,
  output int                     laser_count
);

  localparam int LINE        = `LG_H_TOTAL;
  localparam int FRAME       = `LG_H_TOTAL * `LG_V_TOTAL;
  localparam int BEAM_CYCLES = `LG_LASER_GROW * `LG_GROW_TICKS + `LG_HOLD_TICKS;
  localparam int LATENCY     = 4;

  typedef enum logic [1:0] {
    LASER_IDLE,
    LASER_LEFT,
    LASER_MIDDLE,
    LASER_RIGHT
  } laser_state_t;

  typedef struct packed {
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;
    logic        hit;
  } vga_exp_t;

  // History of the beam FSM and game level, indexed by clock count
  laser_state_t st_hist [8];
  int           age_hist [8];
  logic         game_hist [8];
  int           col_frame [2];

  laser_state_t state;
  int           age;
  int           n;
  int           col_idx;
  logic         ready;
  vga_exp_t     expv;

  function automatic int beam_base(input laser_state_t st);
    case (st)
      LASER_LEFT:   return `LG_LASER_X0;
      LASER_MIDDLE: return `LG_LASER_X1;
      LASER_RIGHT:  return `LG_LASER_X2;
      default:      return 0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference pixel for the output after clock cyc
  ////////////////////////////////////////////////////////////

  function automatic vga_exp_t expected_out(input int cyc, input laser_state_t st,
                                            input int beam_age, input logic game,
                                            input int col);
    vga_exp_t e;
    int       pos;
    int       h;
    int       v;
    int       steps;
    int       left;
    int       right;
    logic     blank;
    logic     on_laser;
    logic     on_player;
    e = '{hsync: 1'b1, vsync: 1'b1, rgb: 12'h000, hit: 1'b0};
    if (cyc < LATENCY) begin
      return e;
    end
    pos   = (cyc - LATENCY) % FRAME;
    h     = pos % LINE;
    v     = pos / LINE;
    steps = beam_age / `LG_GROW_TICKS;
    if (steps > `LG_LASER_GROW) begin
      steps = `LG_LASER_GROW;
    end
    left      = beam_base(st) - steps;
    right     = beam_base(st) + 1 + steps;
    e.hsync   = !((h >= `LG_HS_START) && (h < `LG_HS_END));
    e.vsync   = !((v >= `LG_VS_START) && (v < `LG_VS_END));
    blank     = (h >= `LG_H_ACTIVE) || (v >= `LG_V_ACTIVE);
    on_laser  = (st != LASER_IDLE) && (h >= left) && (h <= right) &&
                (v >= `LG_LASER_TOP) && (v <= `LG_LASER_BOTTOM);
    on_player = game && (v >= `LG_PLAYER_TOP) && (v <= `LG_PLAYER_BOTTOM) &&
                (h >= col) && (h <= col + `LG_PLAYER_W - 1);
    if (!blank) begin
      e.rgb = on_laser ? `LG_LASER_RGB : (on_player ? `LG_PLAYER_RGB : `LG_BG_RGB);
      e.hit = on_laser && on_player;
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input logic [11:0] expected,
                               input logic [11:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s expected %h actual %h at cycle %0d", name, expected, actual, n);
    end
  endtask

  initial begin
    ready       = 1'b0;
    error_count = 0;
    check_count = 0;
    hit_count   = 0;
    laser_count = 0;
    col_frame   = '{0, 0};
  end

  // Beam sequence and frame start sampling, stepped on every clock
  always @(posedge pclk) begin
    if (rst) begin
      n     = 0;
      state = LASER_IDLE;
      age   = 0;
      ready = 1'b1;
    end else begin
      n = n + 1;
      if (state == LASER_IDLE) begin
        if (game_on && !menu_on) begin
          state = LASER_LEFT;
          age   = 0;
        end
      end else if (menu_on || !game_on) begin
        state = LASER_IDLE;
      end else if (age == BEAM_CYCLES - 1) begin
        age   = 0;
        state = (state == LASER_RIGHT) ? LASER_IDLE : laser_state_t'(state + 1);
      end else begin
        age = age + 1;
      end
    end
    st_hist[n % 8]   = state;
    age_hist[n % 8]  = age;
    game_hist[n % 8] = game_on;
    if ((n >= 3) && ((n - 3) % FRAME == 0)) begin
      col_frame[((n - 3) / FRAME) % 2] = player_x;
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparison away from the clock edge
  ////////////////////////////////////////////////////////////

  always @(negedge pclk) begin
    if (ready) begin
      col_idx = (n >= LATENCY) ? ((n - LATENCY) / FRAME) % 2 : 0;
      expv = expected_out(n, st_hist[(n + 5) % 8], age_hist[(n + 5) % 8],
                          game_hist[(n + 7) % 8], col_frame[col_idx]);
      check_count++;
      compare_field("hsync", 12'(expv.hsync), 12'(hsync));
      compare_field("vsync", 12'(expv.vsync), 12'(vsync));
      compare_field("rgb", expv.rgb, rgb);
      compare_field("hit", 12'(expv.hit), 12'(hit));
      if (hit === 1'b1) begin
        hit_count++;
      end
      if (rgb === `LG_LASER_RGB) begin
        laser_count++;
      end
    end
  end

endmodule

// File: tests/laser_game_tb.sv
`timescale 1ns/1ns
`include "laser_game_cfg.svh"

module laser_game_tb;

  localparam int PERIOD       = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int RESET_CYCLES = 4;
  localparam int FRAME        = `LG_H_TOTAL * `LG_V_TOTAL;
  localparam int BEAM         = `LG_LASER_GROW * `LG_GROW_TICKS + `LG_HOLD_TICKS;
  localparam int SEQUENCE     = 3 * BEAM + 1;
  localparam int COL_STEP     = 173;

  // Phase lengths in clocks
  localparam int IDLE_CYCLES   = 2 * FRAME;
  localparam int RUN_CYCLES    = 2 * SEQUENCE + BEAM + 400;
  localparam int MENU_CYCLES   = 1200;
  localparam int RESUME_CYCLES = 500;
  localparam int OFF_CYCLES    = 800;
  localparam int FINAL_CYCLES  = SEQUENCE + FRAME;
  localparam int TAIL_CYCLES   = 2 * FRAME;
  localparam int STIM_CYCLES   = RESET_CYCLES + IDLE_CYCLES + RUN_CYCLES + MENU_CYCLES +
                                 RESUME_CYCLES + OFF_CYCLES + FINAL_CYCLES + TAIL_CYCLES;
  localparam longint TIMEOUT_NS = longint'(STIM_CYCLES + 20 * FRAME) * PERIOD;

  logic                   pclk;
  logic                   rst;
  logic                   game_on;
  logic                   menu_on;
  logic [`LG_COORD_W-1:0] player_x;
  logic                   hsync;
  logic                   vsync;
  logic [11:0]            rgb;
  logic                   hit;

  int error_count;
  int check_count;
  int hit_count;
  int laser_count;
  int seed;
  int cycle_count;

  initial begin
    pclk = 1'b0;
  end

  always #(PERIOD / 2) pclk = ~pclk;

  laser_game_top DUT (
    .pclk     (pclk),
    .rst      (rst),
    .game_on  (game_on),
    .menu_on  (menu_on),
    .player_x (player_x),
    .hsync    (hsync),
    .vsync    (vsync),
    .rgb      (rgb),
    .hit      (hit)
  );

  laser_game_checker u_checker (
    .pclk        (pclk),
    .rst         (rst),
    .game_on     (game_on),
    .menu_on     (menu_on),
    .player_x    (player_x),
    .hsync       (hsync),
    .vsync       (vsync),
    .rgb         (rgb),
    .hit         (hit),
    .error_count (error_count),
    .check_count (check_count),
    .hit_count   (hit_count),
    .laser_count (laser_count)
  );

  // Column moves at odd points inside a frame
  task automatic run_cycles(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge pclk);
      #DRIVE_DELAY;
      cycle_count++;
      if (cycle_count % COL_STEP == 0) begin
        player_x = `LG_COORD_W'($random(seed) & 31);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    game_on     = 1'b0;
    menu_on     = 1'b0;
    player_x    = '0;
    seed        = 75;
    cycle_count = 0;
    repeat (RESET_CYCLES) @(posedge pclk);
    #DRIVE_DELAY;
    rst = 1'b0;
    run_cycles(IDLE_CYCLES);
    game_on = 1'b1;
    run_cycles(RUN_CYCLES);
    // Menu in the middle beam
    menu_on = 1'b1;
    run_cycles(MENU_CYCLES);
    menu_on = 1'b0;
    run_cycles(RESUME_CYCLES);
    game_on = 1'b0;
    run_cycles(OFF_CYCLES);
    game_on = 1'b1;
    run_cycles(FINAL_CYCLES);
    game_on = 1'b0;
    run_cycles(TAIL_CYCLES);
    if (hit_count == 0) begin
      $display("No hit pixel was seen, so the collision was never exercised");
    end
    if (laser_count == 0) begin
      $display("No laser pixel was seen on the output");
    end
    $display("Checked %0d pixels, %0d errors, %0d hit pixels, %0d laser pixels",
             check_count, error_count, hit_count, laser_count);
    if ((error_count == 0) && (hit_count > 0) && (laser_count > 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Run stopped after %0d ns because the stimulus never completed", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: laser_game.f
+incdir+include
src/laser_game_pkg.sv
src/vga_timing.sv
src/laser_obstacle.sv
src/player_collision.sv
src/vga_out.sv
src/laser_game_top.sv
tests/laser_game_checker.sv
tests/laser_game_tb.sv
